//--- verilog/strobe_pkg.sv
// shared widths, types, register map and FSM states, imported by every block of the strobe subsystem
package strobe_pkg;

   // counter width, legal period values start at 2 so the carry vector never goes below one bit
   localparam int period_w    = 16;
   localparam int stat_w      = 16;
   localparam int axil_addr_w = 8;
   localparam int axil_data_w = 32;

   // idle cycles between two strobes
   typedef logic [period_w-1:0]    period_t;
   // ratio and coincidence counts
   typedef logic [stat_w-1:0]      stat_t;
   typedef logic [axil_addr_w-1:0] axil_addr_t;
   typedef logic [axil_data_w-1:0] axil_data_t;
   typedef logic [1:0]             axil_resp_t;

   localparam axil_resp_t resp_okay   = 2'b00;
   localparam axil_resp_t resp_slverr = 2'b10;

   // register map, byte offsets
   localparam axil_addr_t reg_ctrl     = 8'h00;
   localparam axil_addr_t reg_period_a = 8'h04;
   localparam axil_addr_t reg_period_b = 8'h08;
   localparam axil_addr_t reg_ratio    = 8'h0C;
   localparam axil_addr_t reg_coincide = 8'h10;
   localparam axil_addr_t reg_status   = 8'h14;

   // ctrl fields
   localparam int ctrl_en_a = 0;
   localparam int ctrl_en_b = 1;
   // self-clearing, always reads back 0
   localparam int ctrl_clr  = 2;

   // ratio meter progress through the b windows
   typedef enum logic [1:0] {
      m_idle,
      m_first_window,
      m_running
   } meter_state_e;

endpackage

//--- verilog/strobe_stat_if.sv
// statistics path from the ratio meter to the register block, one instance inside the subsystem top
`timescale 1ns/10ps

interface strobe_stat_if
   import strobe_pkg::*;
();

   // a strobes counted in the last complete b window
   stat_t ratio;
   // cycles where both strobes fired, saturating
   stat_t coincide;
   // ratio holds a full window
   logic  ratio_valid;
   // one-cycle pulse that wipes the statistics
   logic  clear;

   modport meter (
      output ratio,
      output coincide,
      output ratio_valid,
      input  clear
   );

   modport regs (
      input  ratio,
      input  coincide,
      input  ratio_valid,
      output clear
   );

endinterface

//--- verilog/strobe_axil_regs.sv
// axi4-lite register slave with enables, periods and clear, reads back status and statistics
`timescale 1ns/10ps

module strobe_axil_regs
   import strobe_pkg::*;
(
   input  logic                     clk_i,
   input  logic                     arst_n_i,
   // write address
   input  axil_addr_t               s_awaddr_i,
   input  logic                     s_awvalid_i,
   output logic                     s_awready_o,
   // write data
   input  axil_data_t               s_wdata_i,
   input  logic [axil_data_w/8-1:0] s_wstrb_i,
   input  logic                     s_wvalid_i,
   output logic                     s_wready_o,
   // write response
   output axil_resp_t               s_bresp_o,
   output logic                     s_bvalid_o,
   input  logic                     s_bready_i,
   // read address
   input  axil_addr_t               s_araddr_i,
   input  logic                     s_arvalid_i,
   output logic                     s_arready_o,
   // read data
   output axil_data_t               s_rdata_o,
   output axil_resp_t               s_rresp_o,
   output logic                     s_rvalid_o,
   input  logic                     s_rready_i,
   // channel a
   output logic                     en_a_o,
   output period_t                  period_a_o,
   output logic                     restart_a_o,
   // channel b
   output logic                     en_b_o,
   output period_t                  period_b_o,
   output logic                     restart_b_o,
   strobe_stat_if.regs              stat
);

   logic       en_a_q;
   logic       en_b_q;
   period_t    period_a_q;
   period_t    period_b_q;
   logic       restart_q;
   logic       clear_q;
   logic       bvalid_q;
   axil_resp_t bresp_q;
   logic       rvalid_q;
   axil_resp_t rresp_q;
   axil_data_t rdata_q;
   logic       wr_accept;
   logic       rd_accept;
   logic       wr_mapped;
   axil_data_t ctrl_rd;
   axil_data_t ctrl_wr;
   axil_data_t period_a_wr;
   axil_data_t period_b_wr;
   axil_data_t rd_data;
   axil_resp_t rd_resp;

   // byte lanes with strobe set take the new data
   function automatic axil_data_t merge_bytes(input axil_data_t old_val,
                                              input axil_data_t new_val,
                                              input logic [axil_data_w/8-1:0] strb);
      axil_data_t result;
      result = old_val;
      for (int i = 0; i < axil_data_w/8; i++)
      begin
         if (strb[i])
         begin
            result[8*i +: 8] = new_val[8*i +: 8];
         end
      end
      return result;
   endfunction

   // address and data taken together, only with no response outstanding
   assign wr_accept   = s_awvalid_i & s_wvalid_i & ~bvalid_q;
   assign s_awready_o = wr_accept;
   assign s_wready_o  = wr_accept;
   // one read in flight at a time
   assign rd_accept   = s_arvalid_i & ~rvalid_q;
   assign s_arready_o = ~rvalid_q;

   // ctrl as seen by software, clr bit never stored
   always_comb
   begin
      ctrl_rd            = '0;
      ctrl_rd[ctrl_en_a] = en_a_q;
      ctrl_rd[ctrl_en_b] = en_b_q;
   end

   assign ctrl_wr     = merge_bytes(ctrl_rd, s_wdata_i, s_wstrb_i);
   assign period_a_wr = merge_bytes(axil_data_t'(period_a_q), s_wdata_i, s_wstrb_i);
   assign period_b_wr = merge_bytes(axil_data_t'(period_b_q), s_wdata_i, s_wstrb_i);

   // read decode, statistics are already registered in the meter
   always_comb
   begin
      rd_data   = '0;
      rd_resp   = resp_okay;
      wr_mapped = 1'b1;
      case (s_araddr_i)
         reg_ctrl:     rd_data = ctrl_rd;
         reg_period_a: rd_data = axil_data_t'(period_a_q);
         reg_period_b: rd_data = axil_data_t'(period_b_q);
         reg_ratio:    rd_data = axil_data_t'(stat.ratio);
         reg_coincide: rd_data = axil_data_t'(stat.coincide);
         reg_status:   rd_data[0] = stat.ratio_valid;
         default:      rd_resp = resp_slverr;
      endcase
      // same map on the write side, ratio and status writes are ignored
      case (s_awaddr_i)
         reg_ctrl, reg_period_a, reg_period_b,
         reg_ratio, reg_coincide, reg_status: wr_mapped = 1'b1;
         default:                             wr_mapped = 1'b0;
      endcase
   end

   // write channel and register updates
   always_ff @(posedge clk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         en_a_q     <= 1'b0;
         en_b_q     <= 1'b0;
         period_a_q <= '0;
         period_b_q <= '0;
         restart_q  <= 1'b0;
         clear_q    <= 1'b0;
         bvalid_q   <= 1'b0;
         bresp_q    <= resp_okay;
      end
      else
      begin
         // pulses last a single cycle
         restart_q <= 1'b0;
         clear_q   <= 1'b0;
         if (wr_accept)
         begin
            bvalid_q <= 1'b1;
            bresp_q  <= wr_mapped ? resp_okay : resp_slverr;
            case (s_awaddr_i)
               reg_ctrl:
               begin
                  en_a_q    <= ctrl_wr[ctrl_en_a];
                  en_b_q    <= ctrl_wr[ctrl_en_b];
                  // any rising enable restarts both channels so they stay in phase
                  restart_q <= (ctrl_wr[ctrl_en_a] & ~en_a_q) |
                               (ctrl_wr[ctrl_en_b] & ~en_b_q);
                  clear_q   <= ctrl_wr[ctrl_clr];
               end
               reg_period_a: period_a_q <= period_a_wr[period_w-1:0];
               reg_period_b: period_b_q <= period_b_wr[period_w-1:0];
               default:
               begin
               end
            endcase
         end
         else if (bvalid_q && s_bready_i)
         begin
            bvalid_q <= 1'b0;
         end
      end
   end

   // read channel
   always_ff @(posedge clk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         rvalid_q <= 1'b0;
         rresp_q  <= resp_okay;
         rdata_q  <= '0;
      end
      else if (rd_accept)
      begin
         rvalid_q <= 1'b1;
         rresp_q  <= rd_resp;
         rdata_q  <= rd_data;
      end
      else if (rvalid_q && s_rready_i)
      begin
         rvalid_q <= 1'b0;
      end
   end

   assign s_bvalid_o  = bvalid_q;
   assign s_bresp_o   = bresp_q;
   assign s_rvalid_o  = rvalid_q;
   assign s_rresp_o   = rresp_q;
   assign s_rdata_o   = rdata_q;
   assign en_a_o      = en_a_q;
   assign en_b_o      = en_b_q;
   assign period_a_o  = period_a_q;
   assign period_b_o  = period_b_q;
   assign restart_a_o = restart_q;
   assign restart_b_o = restart_q;
   assign stat.clear  = clear_q;

endmodule

//--- verilog/cs_strobe_gen.sv
// carry-save strobe counter, emits one strobe then period_i idle cycles, one instance per channel
`timescale 1ns/10ps

module cs_strobe_gen
   import strobe_pkg::*;
(
   input  logic    clk_i,
   input  logic    arst_n_i,
   input  logic    en_i,
   input  logic    restart_i,
   input  period_t period_i,
   output logic    strobe_o
);

   // count kept as sum plus carries shifted up one place
   period_t             sum_q;
   logic [period_w-2:0] carry_q;
   period_t             sum_d;
   logic [period_w-2:0] carry_d;
   period_t             carry_in;
   logic                term;

   // the increment enters at bit 0, stored carries sit above it
   assign carry_in = {carry_q, 1'b1};

   // -1 shows up as every sum bit set, a single and-reduce and no carry chain
   // no terminal count in a restart cycle
   assign term = en_i & ~restart_i & (&sum_q);

   always_comb
   begin
      // one half adder per bit, top carry drops off
      sum_d   = sum_q ^ carry_in;
      carry_d = sum_q[period_w-2:0] & carry_in[period_w-2:0];
      if (restart_i)
      begin
         // preload the terminal value so the first strobe follows at once
         sum_d   = '1;
         carry_d = '0;
      end
      else if (term)
      begin
         // ~n is -(n+1), so n idle cycles pass before the next terminal count
         // the period is only taken here, which makes a switch atomic
         sum_d   = ~period_i;
         carry_d = '0;
      end
   end

   always_ff @(posedge clk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         sum_q   <= '0;
         carry_q <= '0;
      end
      else if (en_i || restart_i)
      begin
         // counter freezes while disabled
         sum_q   <= sum_d;
         carry_q <= carry_d;
      end
   end

   // registered terminal flag
   always_ff @(posedge clk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         strobe_o <= 1'b0;
      end
      else
      begin
         strobe_o <= term;
      end
   end

endmodule

//--- verilog/strobe_ratio_meter.sv
// counts a strobes per b window and coincident strobes, feeds the statistics interface
`timescale 1ns/10ps

module strobe_ratio_meter
   import strobe_pkg::*;
(
   input logic          clk_i,
   input logic          arst_n_i,
   input logic          strobe_a_i,
   input logic          strobe_b_i,
   strobe_stat_if.meter stat
);

   meter_state_e state_q;
   meter_state_e state_d;
   stat_t        a_cnt_q;
   stat_t        a_cnt_inc;
   stat_t        ratio_q;
   stat_t        coincide_q;
   logic         both;

   // running window count, an a strobe on the closing b edge still belongs to it
   assign a_cnt_inc = (strobe_a_i && (a_cnt_q != '1)) ? a_cnt_q + stat_t'(1) : a_cnt_q;
   assign both      = strobe_a_i & strobe_b_i;

   // advance one step per b strobe until a full window has been seen
   always_comb
   begin
      state_d = state_q;
      if (strobe_b_i)
      begin
         case (state_q)
            m_idle:         state_d = m_first_window;
            m_first_window: state_d = m_running;
            default:        state_d = m_running;
         endcase
      end
   end

   always_ff @(posedge clk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         state_q    <= m_idle;
         a_cnt_q    <= '0;
         ratio_q    <= '0;
         coincide_q <= '0;
      end
      else if (stat.clear)
      begin
         // start over, the next window is partial again
         state_q    <= m_idle;
         a_cnt_q    <= '0;
         ratio_q    <= '0;
         coincide_q <= '0;
      end
      else
      begin
         state_q <= state_d;
         if (strobe_b_i)
         begin
            a_cnt_q <= '0;
            // nothing to latch before the first b strobe opens a window
            if (state_q != m_idle)
            begin
               ratio_q <= a_cnt_inc;
            end
         end
         else
         begin
            a_cnt_q <= a_cnt_inc;
         end
         // saturates at all ones
         if (both && (coincide_q != '1))
         begin
            coincide_q <= coincide_q + stat_t'(1);
         end
      end
   end

   assign stat.ratio       = ratio_q;
   assign stat.coincide    = coincide_q;
   // high from the cycle after the second b strobe
   assign stat.ratio_valid = (state_q == m_running);

endmodule

//--- verilog/strobe_subsys_top.sv
// top of the tick generator, axi4-lite registers driving two strobe channels and a ratio meter
`timescale 1ns/10ps

module strobe_subsys_top
   import strobe_pkg::*;
(
   input  logic                     clk_i,
   input  logic                     arst_n_i,
   // axi4-lite slave
   input  axil_addr_t               s_awaddr_i,
   input  logic                     s_awvalid_i,
   output logic                     s_awready_o,
   input  axil_data_t               s_wdata_i,
   input  logic [axil_data_w/8-1:0] s_wstrb_i,
   input  logic                     s_wvalid_i,
   output logic                     s_wready_o,
   output axil_resp_t               s_bresp_o,
   output logic                     s_bvalid_o,
   input  logic                     s_bready_i,
   input  axil_addr_t               s_araddr_i,
   input  logic                     s_arvalid_i,
   output logic                     s_arready_o,
   output axil_data_t               s_rdata_o,
   output axil_resp_t               s_rresp_o,
   output logic                     s_rvalid_o,
   input  logic                     s_rready_i,
   // strobes
   output logic                     strobe_a_o,
   output logic                     strobe_b_o
);

   logic    en_a;
   logic    en_b;
   period_t period_a;
   period_t period_b;
   logic    restart_a;
   logic    restart_b;

   // statistics from meter to registers
   strobe_stat_if u_stat ();

   strobe_axil_regs u_regs (
      .clk_i       (clk_i),
      .arst_n_i    (arst_n_i),
      .s_awaddr_i  (s_awaddr_i),
      .s_awvalid_i (s_awvalid_i),
      .s_awready_o (s_awready_o),
      .s_wdata_i   (s_wdata_i),
      .s_wstrb_i   (s_wstrb_i),
      .s_wvalid_i  (s_wvalid_i),
      .s_wready_o  (s_wready_o),
      .s_bresp_o   (s_bresp_o),
      .s_bvalid_o  (s_bvalid_o),
      .s_bready_i  (s_bready_i),
      .s_araddr_i  (s_araddr_i),
      .s_arvalid_i (s_arvalid_i),
      .s_arready_o (s_arready_o),
      .s_rdata_o   (s_rdata_o),
      .s_rresp_o   (s_rresp_o),
      .s_rvalid_o  (s_rvalid_o),
      .s_rready_i  (s_rready_i),
      .en_a_o      (en_a),
      .period_a_o  (period_a),
      .restart_a_o (restart_a),
      .en_b_o      (en_b),
      .period_b_o  (period_b),
      .restart_b_o (restart_b),
      .stat        (u_stat)
   );

   // channel a
   cs_strobe_gen u_gen_a (
      .clk_i     (clk_i),
      .arst_n_i  (arst_n_i),
      .en_i      (en_a),
      .restart_i (restart_a),
      .period_i  (period_a),
      .strobe_o  (strobe_a_o)
   );

   // channel b, its strobes close the meter windows
   cs_strobe_gen u_gen_b (
      .clk_i     (clk_i),
      .arst_n_i  (arst_n_i),
      .en_i      (en_b),
      .restart_i (restart_b),
      .period_i  (period_b),
      .strobe_o  (strobe_b_o)
   );

   strobe_ratio_meter u_meter (
      .clk_i      (clk_i),
      .arst_n_i   (arst_n_i),
      .strobe_a_i (strobe_a_o),
      .strobe_b_i (strobe_b_o),
      .stat       (u_stat)
   );

endmodule

//--- tests/strobe_subsys_tb.sv
// self-checking testbench for the strobe subsystem, drives axi4-lite and times both strobe outputs
`timescale 1ns/10ps

module strobe_subsys_tb
   import strobe_pkg::*;
();

   localparam int clk_period_ns = 8;
   localparam int table_len     = 5;
   // longest wait in the table, sizes the watchdog
   localparam int max_wait_cyc  = 220;
   localparam int watchdog_cyc  = table_len * max_wait_cyc + 4000;

   // one in-phase ratio test, period b plus one is a multiple of period a plus one
   typedef struct {
      period_t    pa;
      period_t    pb;
      int         wait_cyc;
      stat_t      exp_ratio;
      int         min_b;
      axil_resp_t exp_resp;
   } test_entry_t;

   logic                     clk_i = 1'b0;
   logic                     arst_n_i;
   axil_addr_t               s_awaddr_i;
   logic                     s_awvalid_i;
   logic                     s_awready_o;
   axil_data_t               s_wdata_i;
   logic [axil_data_w/8-1:0] s_wstrb_i;
   logic                     s_wvalid_i;
   logic                     s_wready_o;
   axil_resp_t               s_bresp_o;
   logic                     s_bvalid_o;
   logic                     s_bready_i;
   axil_addr_t               s_araddr_i;
   logic                     s_arvalid_i;
   logic                     s_arready_o;
   axil_data_t               s_rdata_o;
   axil_resp_t               s_rresp_o;
   logic                     s_rvalid_o;
   logic                     s_rready_i;
   logic                     strobe_a_o;
   logic                     strobe_b_o;

   test_entry_t tests [table_len];
   // edge times of every strobe seen so far
   time         a_times[$];
   time         b_times[$];
   integer      seed        = 93587;
   int          error_cnt   = 0;
   int          check_cnt   = 0;
   // b strobes counted when the last read address went out
   int          issue_b_cnt = 0;

   strobe_subsys_top dut (
      .clk_i       (clk_i),
      .arst_n_i    (arst_n_i),
      .s_awaddr_i  (s_awaddr_i),
      .s_awvalid_i (s_awvalid_i),
      .s_awready_o (s_awready_o),
      .s_wdata_i   (s_wdata_i),
      .s_wstrb_i   (s_wstrb_i),
      .s_wvalid_i  (s_wvalid_i),
      .s_wready_o  (s_wready_o),
      .s_bresp_o   (s_bresp_o),
      .s_bvalid_o  (s_bvalid_o),
      .s_bready_i  (s_bready_i),
      .s_araddr_i  (s_araddr_i),
      .s_arvalid_i (s_arvalid_i),
      .s_arready_o (s_arready_o),
      .s_rdata_o   (s_rdata_o),
      .s_rresp_o   (s_rresp_o),
      .s_rvalid_o  (s_rvalid_o),
      .s_rready_i  (s_rready_i),
      .strobe_a_o  (strobe_a_o),
      .strobe_b_o  (strobe_b_o)
   );

   always #(clk_period_ns / 2) clk_i = ~clk_i;

   // channel a monitor, samples on the same edge as the meter
   always @(posedge clk_i)
   begin
      if (strobe_a_o)
      begin
         a_times.push_back($time);
      end
   end

   // channel b monitor
   always @(posedge clk_i)
   begin
      if (strobe_b_o)
      begin
         b_times.push_back($time);
      end
   end

   initial
   begin
      #(watchdog_cyc * clk_period_ns);
      $display("simulation timed out after %0d clock cycles", watchdog_cyc);
      $display("TESTS FAILED");
      $finish;
   end

   task automatic check_data(input string what, input axil_data_t got, input axil_data_t exp);
      check_cnt++;
      if (got !== exp)
      begin
         error_cnt++;
         $display("Error at %0t: %s is 0x%0h, expected 0x%0h", $time, what, got, exp);
      end
   endtask

   task automatic check_resp(input string what, input axil_resp_t got, input axil_resp_t exp);
      check_cnt++;
      if (got !== exp)
      begin
         error_cnt++;
         $display("Error at %0t: %s is %0d, expected %0d", $time, what, got, exp);
      end
   endtask

   task automatic check_period(input string what, input period_t got, input period_t exp);
      check_cnt++;
      if (got !== exp)
      begin
         error_cnt++;
         $display("Error at %0t: %s of %0d idle cycles, expected %0d", $time, what, got, exp);
      end
   endtask

   task automatic check_stat(input string what, input stat_t got, input stat_t exp);
      check_cnt++;
      if (got !== exp)
      begin
         error_cnt++;
         $display("Error at %0t: %s is %0d, expected %0d", $time, what, got, exp);
      end
   endtask

   task automatic report_problem(input string what);
      error_cnt++;
      $display("%s, at %0t", what, $time);
   endtask

   function automatic axil_data_t ctrl_word(input logic en_a, input logic en_b, input logic clr);
      axil_data_t word;
      word            = '0;
      word[ctrl_en_a] = en_a;
      word[ctrl_en_b] = en_b;
      word[ctrl_clr]  = clr;
      return word;
   endfunction

   // distance between two strobe edges, minus the strobe cycle itself
   function automatic period_t idle_cycles(input time gap);
      return period_t'(gap / clk_period_ns - 1);
   endfunction

   // address and data go out together, bready lags by 0 to 3 cycles
   task automatic write_reg(input axil_addr_t addr, input axil_data_t data,
                            output axil_resp_t resp);
      int stall;
      @(negedge clk_i);
      s_awaddr_i  = addr;
      s_awvalid_i = 1'b1;
      s_wdata_i   = data;
      s_wstrb_i   = '1;
      s_wvalid_i  = 1'b1;
      // both readies follow the valids within the low phase
      #(clk_period_ns / 4);
      if (s_awready_o !== 1'b1 || s_wready_o !== 1'b1)
      begin
         report_problem("awready or wready stayed low with address and data valid");
      end
      @(negedge clk_i);
      // bvalid rises on the accepting edge
      while (!s_bvalid_o)
      begin
         @(negedge clk_i);
      end
      if (s_awready_o !== 1'b0 || s_wready_o !== 1'b0)
      begin
         report_problem("awready or wready high while a write response was pending");
      end
      s_awvalid_i = 1'b0;
      s_wvalid_i  = 1'b0;
      stall       = $random(seed) & 3;
      repeat (stall) @(negedge clk_i);
      resp        = s_bresp_o;
      s_bready_i  = 1'b1;
      @(negedge clk_i);
      s_bready_i  = 1'b0;
   endtask

   task automatic read_reg(input axil_addr_t addr, output axil_data_t data,
                           output axil_resp_t resp);
      int stall;
      @(negedge clk_i);
      if (s_arready_o !== 1'b1)
      begin
         report_problem("arready low with no read response pending");
      end
      s_araddr_i  = addr;
      s_arvalid_i = 1'b1;
      issue_b_cnt = b_times.size();
      @(negedge clk_i);
      while (!s_rvalid_o)
      begin
         @(negedge clk_i);
      end
      if (s_arready_o !== 1'b0)
      begin
         report_problem("arready high while a read response was pending");
      end
      s_arvalid_i = 1'b0;
      data        = s_rdata_o;
      resp        = s_rresp_o;
      // rready lags, rvalid must hold meanwhile
      stall       = $random(seed) & 3;
      repeat (stall) @(negedge clk_i);
      s_rready_i  = 1'b1;
      @(negedge clk_i);
      s_rready_i  = 1'b0;
   endtask

   task automatic write_checked(input axil_addr_t addr, input axil_data_t data,
                                input axil_resp_t exp_resp);
      axil_resp_t rsp;
      write_reg(addr, data, rsp);
      check_resp($sformatf("write 0x%02h response", addr), rsp, exp_resp);
   endtask

   task automatic read_checked(input axil_addr_t addr, input axil_data_t exp_data,
                               input axil_resp_t exp_resp);
      axil_data_t rd;
      axil_resp_t rsp;
      read_reg(addr, rd, rsp);
      check_resp($sformatf("read 0x%02h response", addr), rsp, exp_resp);
      check_data($sformatf("read 0x%02h data", addr), rd, exp_data);
   endtask

   // every gap recorded after mark must be n idle cycles
   task automatic check_gaps(input bit chan_b, input int mark, input period_t n);
      int    cnt;
      time   gap;
      string what;
      cnt  = chan_b ? b_times.size() : a_times.size();
      what = chan_b ? "channel b gap" : "channel a gap";
      for (int i = mark + 1; i < cnt; i++)
      begin
         gap = chan_b ? b_times[i] - b_times[i-1] : a_times[i] - a_times[i-1];
         check_period(what, idle_cycles(gap), n);
      end
   endtask

   task automatic reset_value_test();
      read_checked(reg_ctrl, '0, resp_okay);
      read_checked(reg_period_a, '0, resp_okay);
      read_checked(reg_period_b, '0, resp_okay);
      read_checked(reg_ratio, '0, resp_okay);
      read_checked(reg_coincide, '0, resp_okay);
      read_checked(reg_status, '0, resp_okay);
      // observation window with both enables off
      repeat (20) @(negedge clk_i);
      if (a_times.size() != 0 || b_times.size() != 0)
      begin
         report_problem("a strobe fired while both enables were off");
      end
   endtask

   task automatic run_entry(input test_entry_t e);
      axil_data_t rd;
      axil_resp_t rsp;
      stat_t      exp_coinc;
      int         mark_a;
      int         mark_b;
      int         waited;
      // stop both channels first so the clear sees no late strobe
      write_checked(reg_ctrl, ctrl_word(1'b0, 1'b0, 1'b0), resp_okay);
      write_checked(reg_ctrl, ctrl_word(1'b0, 1'b0, 1'b1), resp_okay);
      write_checked(reg_period_a, axil_data_t'(e.pa), resp_okay);
      write_checked(reg_period_b, axil_data_t'(e.pb), resp_okay);
      read_checked(reg_period_a, axil_data_t'(e.pa), resp_okay);
      read_checked(reg_period_b, axil_data_t'(e.pb), resp_okay);
      mark_a = a_times.size();
      mark_b = b_times.size();
      // one write raises both enables, channels start in phase
      write_checked(reg_ctrl, ctrl_word(1'b1, 1'b1, 1'b0), resp_okay);
      waited = 0;
      while (b_times.size() - mark_b < e.min_b && waited < e.wait_cyc)
      begin
         @(negedge clk_i);
         waited++;
      end
      if (b_times.size() - mark_b < e.min_b)
      begin
         report_problem("channel b gave too few strobes within the wait");
      end
      read_reg(reg_ratio, rd, rsp);
      check_resp("ratio response", rsp, e.exp_resp);
      check_stat("ratio", stat_t'(rd), e.exp_ratio);
      read_checked(reg_status, axil_data_t'(1), e.exp_resp);
      read_reg(reg_coincide, rd, rsp);
      check_resp("coincide response", rsp, e.exp_resp);
      // each b strobe meets an a strobe, one more may land while the read is in flight
      exp_coinc = stat_t'(issue_b_cnt - mark_b);
      if (stat_t'(rd) == exp_coinc + stat_t'(1) || stat_t'(rd) + stat_t'(1) == exp_coinc)
      begin
         exp_coinc = stat_t'(rd);
      end
      check_stat("coincide", stat_t'(rd), exp_coinc);
      check_gaps(1'b0, mark_a, e.pa);
      check_gaps(1'b1, mark_b, e.pb);
      // clear with enables dropped, counts stay at zero afterwards
      write_checked(reg_ctrl, ctrl_word(1'b0, 1'b0, 1'b1), resp_okay);
      read_checked(reg_coincide, '0, resp_okay);
      read_checked(reg_status, '0, resp_okay);
   endtask

   // channel a period rewritten mid-interval, gaps go old then new and never back
   task automatic period_switch_test(input period_t old_n, input period_t new_n);
      int      mark_a;
      int      mark_w;
      bit      seen_new;
      period_t n;
      period_t exp_n;
      write_checked(reg_ctrl, ctrl_word(1'b0, 1'b0, 1'b0), resp_okay);
      write_checked(reg_period_a, axil_data_t'(old_n), resp_okay);
      mark_a = a_times.size();
      write_checked(reg_ctrl, ctrl_word(1'b1, 1'b0, 1'b0), resp_okay);
      while (a_times.size() - mark_a < 3)
      begin
         @(negedge clk_i);
      end
      while (!strobe_a_o)
      begin
         @(negedge clk_i);
      end
      repeat (int'(old_n) / 2) @(negedge clk_i);
      write_checked(reg_period_a, axil_data_t'(new_n), resp_okay);
      mark_w = a_times.size();
      while (a_times.size() - mark_w < 4)
      begin
         @(negedge clk_i);
      end
      seen_new = 1'b0;
      for (int i = mark_a + 1; i < a_times.size(); i++)
      begin
         n     = idle_cycles(a_times[i] - a_times[i-1]);
         // old length allowed only before the first new-length gap
         exp_n = (!seen_new && n == old_n) ? old_n : new_n;
         if (n == new_n)
         begin
            seen_new = 1'b1;
         end
         check_period("channel a gap around period switch", n, exp_n);
      end
      if (!seen_new)
      begin
         report_problem("channel a never switched to the new period");
      end
   endtask

   // unmapped offsets answer slverr and leave the register file alone
   task automatic error_response_test(input period_t exp_pa, input period_t exp_pb);
      axil_data_t rd;
      axil_resp_t rsp;
      write_checked(8'h18, 32'h0000_0003, resp_slverr);
      write_checked(8'hFC, 32'h0000_FFFF, resp_slverr);
      read_reg(8'h18, rd, rsp);
      check_resp("read 0x18 response", rsp, resp_slverr);
      read_reg(8'hFC, rd, rsp);
      check_resp("read 0xfc response", rsp, resp_slverr);
      read_checked(reg_ctrl, ctrl_word(1'b1, 1'b0, 1'b0), resp_okay);
      read_checked(reg_period_a, axil_data_t'(exp_pa), resp_okay);
      read_checked(reg_period_b, axil_data_t'(exp_pb), resp_okay);
   endtask

   initial
   begin
      arst_n_i    = 1'b0;
      s_awaddr_i  = '0;
      s_awvalid_i = 1'b0;
      s_wdata_i   = '0;
      s_wstrb_i   = '0;
      s_wvalid_i  = 1'b0;
      s_bready_i  = 1'b0;
      s_araddr_i  = '0;
      s_arvalid_i = 1'b0;
      s_rready_i  = 1'b0;
      // period a, period b, wait cycles, ratio, b strobes to collect, response
      tests[0] = '{16'd2, 16'd8, 60, 16'd3, 5, resp_okay};
      tests[1] = '{16'd3, 16'd15, 100, 16'd4, 4, resp_okay};
      tests[2] = '{16'd4, 16'd4, 60, 16'd1, 6, resp_okay};
      tests[3] = '{16'd6, 16'd48, 220, 16'd7, 4, resp_okay};
      tests[4] = '{16'd9, 16'd29, 160, 16'd3, 4, resp_okay};
      repeat (8) @(posedge clk_i);
      @(negedge clk_i);
      arst_n_i = 1'b1;
      reset_value_test();
      for (int i = 0; i < table_len; i++)
      begin
         run_entry(tests[i]);
      end
      period_switch_test(16'd11, 16'd3);
      error_response_test(16'd3, tests[table_len-1].pb);
      $display("checks run: %0d, errors: %0d", check_cnt, error_cnt);
      if (error_cnt == 0)
      begin
         $display("TESTS PASSED");
      end
      else
      begin
         $display("TESTS FAILED");
      end
      $finish;
   end

endmodule

//--- flist.f
verilog/strobe_pkg.sv
verilog/strobe_stat_if.sv
verilog/strobe_axil_regs.sv
verilog/cs_strobe_gen.sv
verilog/strobe_ratio_meter.sv
verilog/strobe_subsys_top.sv
tests/strobe_subsys_tb.sv

//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing -j 0
TOP       := strobe_subsys_tb
FLIST     := flist.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell grep -v '^+' $(FLIST))

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1 || true
	cat $(LOG)
	! grep -q "TESTS FAILED" $(LOG)
	grep -q "TESTS PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
